//--- hdl/mem_macros.svh
/* memory subsystem constants
   burst RAM latencies, cache geometry and the RAM power-up pattern. */

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ram latencies in cycles, both have a minimum of 3.
`define RD_LATENCY 5
`define WR_LATENCY 5

`define LINE_WORDS 8     // fixed by the ram burst length.
`define CACHE_LINES 64   // direct mapped, one way.

// every ram word powers up as its own word address xor this.
`define RAM_INIT_XOR 32'h5A5A_0F0F

`endif

//--- hdl/mem_pkg.sv
/* memory-side types
   word, word address and line offset as seen on the burst RAM port. */

package mem_pkg;

  // 32-bit data word.
  typedef logic [31:0] word_t;

  // word address, 4M words.
  typedef logic [21:0] waddr_t;

  typedef logic [2:0] offset_t;   // word position inside an 8-word line.

endpackage

//--- hdl/cache_pkg.sv
/* cache-side types
   address split, tag array entry and controller states. */

package cache_pkg;

  typedef logic [12:0] tag_t;     // upper address bits.
  typedef logic [5:0] index_t;    // selects one of the 64 lines.

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    idle,
    lookup,      // array read.
    evict_req,
    evict,
    fill_req,
    fill,
    respond      // tag compare and answer.
  } cache_state_t;

endpackage

//--- hdl/cache_array.sv
/* cache_array
   single-port storage with a registered read, shared by the tag and
   data arrays of the cache. */

`timescale 1ns/1ns

module cache_array import cache_pkg::*; #(
  parameter type entry_t = tag_entry_t,
  parameter int DEPTH = 64
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     we,
  input  entry_t                   wdata,
  output entry_t                   rdata
);

  entry_t mem [DEPTH];

  // read returns the old entry when written in the same cycle.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- hdl/burst_ram.sv
/* burst_ram
   external RAM model, 4M x 32. one request moves a whole 8-word line,
   critical word first, with the address wrapping inside the line. */

`timescale 1ns/1ns
`include "mem_macros.svh"

module burst_ram import mem_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   mem_stb,
  input  logic   mem_we,
  input  waddr_t mem_addr,
  input  word_t  mem_wdata,
  output word_t  mem_rdata,
  output logic   mem_ack
);

  localparam int MEM_WORDS = 1 << $bits(waddr_t);

  word_t mem [MEM_WORDS];
  logic we_buf;
  waddr_t addr_buf;
  logic [3:0] latency_cnt;
  logic [3:0] beat_cnt;
  logic xfer_start;
  logic xfer_stop;
  logic ram_idle;
  logic rd_ack;
  offset_t ram_off;
  waddr_t ram_addr;

  assign ram_idle = (latency_cnt == 4'd0) && xfer_stop;

  // latency countdown, loaded when a request is taken.
  always_ff @(posedge clk) begin
    if (rst) begin
      latency_cnt <= 4'd0;
      we_buf <= 1'b0;
    end else if (latency_cnt != 4'd0) begin
      latency_cnt <= latency_cnt - 4'd1;
    end else if (ram_idle && mem_stb) begin
      latency_cnt <= mem_we ? 4'(`WR_LATENCY - 2) : 4'(`RD_LATENCY - 2);
      we_buf <= mem_we;
    end
  end

  always_ff @(posedge clk) begin
    if (ram_idle && mem_stb) begin
      addr_buf <= mem_addr;   // critical word address.
    end
  end

  assign xfer_start = (latency_cnt == 4'd1);
  assign xfer_stop = beat_cnt[3];

  // beat window, 8 cycles long.
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= 4'd8;
    end else if (xfer_start) begin
      beat_cnt <= 4'd0;
    end else if (!xfer_stop) begin
      beat_cnt <= beat_cnt + 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= !xfer_stop && !we_buf;   // lines up with the registered data.
    end
  end

  assign mem_ack = we_buf ? !xfer_stop : rd_ack;

  assign ram_off = addr_buf[2:0] + beat_cnt[2:0];   // wraps inside the line.
  assign ram_addr = {addr_buf[$bits(waddr_t)-1:3], ram_off};

  always @(posedge clk) begin
    if (!xfer_stop) begin
      if (we_buf) begin
        mem[ram_addr] <= mem_wdata;
      end else begin
        mem_rdata <= mem[ram_addr];
      end
    end
  end

  // power-up contents follow the address pattern.
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = word_t'(i) ^ `RAM_INIT_XOR;
    end
  end

  // the master may only ask while the ram is idle.
  assert property (@(posedge clk) disable iff (rst) !ram_idle |-> !mem_stb)
    else $error("burst_ram: request raised while a burst is in progress.");

endmodule

//--- hdl/line_cache.sv
/* line_cache
   write-back direct-mapped cache, 64 lines of 8 words. Wishbone classic
   slave towards the cpu, burst master towards the external ram. */

`timescale 1ns/1ns
`include "mem_macros.svh"

module line_cache import mem_pkg::*, cache_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   cyc,
  input  logic   stb,
  input  logic   we,
  input  waddr_t adr,
  input  word_t  dat_w,
  output word_t  dat_r,
  output logic   ack,
  output logic   mem_stb,
  output logic   mem_we,
  output waddr_t mem_addr,
  output word_t  mem_wdata,
  input  word_t  mem_rdata,
  input  logic   mem_ack
);

  localparam int SWEEP_W = $clog2(`CACHE_LINES) + 1;
  localparam int DATA_DEPTH = `CACHE_LINES * `LINE_WORDS;
  localparam offset_t LAST_BEAT = offset_t'(`LINE_WORDS - 1);

  cache_state_t state;
  logic [SWEEP_W-1:0] sweep_cnt;
  logic sweeping;
  offset_t beat;
  logic last_beat;
  tag_t adr_tag;
  index_t adr_idx;
  offset_t adr_off;
  index_t tag_addr;
  logic tag_we;
  tag_entry_t tag_wr;
  tag_entry_t tag_rd;
  logic data_we;
  offset_t data_off;
  word_t data_wr;
  word_t data_rd;
  logic hit;

  assign {adr_tag, adr_idx, adr_off} = adr;
  assign sweeping = !sweep_cnt[SWEEP_W-1];
  assign hit = tag_rd.valid && (tag_rd.tag == adr_tag);
  assign last_beat = mem_ack && (beat == LAST_BEAT);

  // walk the tag array once after reset to clear the valid bits.
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_cnt <= '0;
    end else if (sweeping) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  assign tag_addr = sweeping ? sweep_cnt[SWEEP_W-2:0] : adr_idx;

  always_comb begin
    tag_we = 1'b0;
    tag_wr = '0;
    if (sweeping) begin
      tag_we = 1'b1;
    end else if (state == respond && hit && we) begin
      tag_we = 1'b1;
      tag_wr = '{valid: 1'b1, dirty: 1'b1, tag: adr_tag};
    end else if (state == fill && last_beat) begin
      tag_we = 1'b1;
      tag_wr = '{valid: 1'b1, dirty: 1'b0, tag: adr_tag};
    end
  end

  always_comb begin
    data_we = 1'b0;
    data_wr = dat_w;
    data_off = adr_off;
    case (state)
      // prefetch the next victim word on every write beat.
      evict_req, evict: data_off = mem_ack ? beat + 1'b1 : beat;
      fill: begin
        data_we = mem_ack;
        data_wr = mem_rdata;
        data_off = adr_off + beat;   // same wrap order as the ram.
      end
      respond: data_we = hit && we;
      default: ;
    endcase
  end

  cache_array #(.entry_t(tag_entry_t), .DEPTH(`CACHE_LINES)) tag_array_i (
    .clk   (clk),
    .addr  (tag_addr),
    .we    (tag_we),
    .wdata (tag_wr),
    .rdata (tag_rd)
  );

  cache_array #(.entry_t(word_t), .DEPTH(DATA_DEPTH)) data_array_i (
    .clk   (clk),
    .addr  ({adr_idx, data_off}),
    .we    (data_we),
    .wdata (data_wr),
    .rdata (data_rd)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      ack <= 1'b0;
      beat <= '0;
    end else begin
      ack <= 1'b0;
      if (mem_ack) begin
        beat <= beat + 1'b1;   // 8 acks bring it back to 0.
      end
      case (state)
        idle: if (cyc && stb && !ack && !sweeping) state <= lookup;
        lookup: state <= respond;
        respond: begin
          if (hit) begin
            ack <= 1'b1;
            state <= idle;
          end else if (tag_rd.valid && tag_rd.dirty) begin
            state <= evict_req;
          end else begin
            state <= fill_req;
          end
        end
        evict_req: state <= evict;
        evict: if (last_beat) state <= fill_req;
        fill_req: state <= fill;
        fill: if (last_beat) state <= lookup;   // retry now hits.
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == respond && hit) begin
      dat_r <= data_rd;
    end
  end

  // victim line goes out from offset 0, fills start at the cpu word.
  assign mem_stb = (state == evict_req) || (state == fill_req);
  assign mem_we = (state == evict_req);
  assign mem_addr = mem_we ? {tag_rd.tag, adr_idx, offset_t'(0)} : adr;
  assign mem_wdata = data_rd;

  assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
    else $error("line_cache: ack outside a Wishbone cycle.");

  // requests only go out between bursts, with the beat count back at zero.
  assert property (@(posedge clk) disable iff (rst)
    mem_stb |-> !mem_ack && (beat == '0))
    else $error("line_cache: burst request overlaps a running burst.");

endmodule

//--- hdl/cached_mem.sv
/* cached_mem
   cpu-facing memory subsystem, the line cache in front of the
   external burst RAM. */

`timescale 1ns/1ns

module cached_mem import mem_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   cyc,
  input  logic   stb,
  input  logic   we,
  input  waddr_t adr,
  input  word_t  dat_w,
  output word_t  dat_r,
  output logic   ack
);

  // burst link between cache and ram.
  logic   mem_stb;
  logic   mem_we;
  waddr_t mem_addr;
  word_t  mem_wdata;
  word_t  mem_rdata;
  logic   mem_ack;

  line_cache line_cache_i (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

  burst_ram burst_ram_i (
    .clk       (clk),
    .rst       (rst),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

endmodule

//--- bench/cached_mem_tb.sv
/* cached_mem testbench
   replays a trace of Wishbone reads and writes against the cached memory,
   checks the read data and the hit latency. */

`timescale 1ns/1ns
`include "mem_macros.svh"

module cached_mem_tb import mem_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int HIT_CYCLES = 2;       // array read, then tag compare.
  localparam int CYCLES_PER_OP = 40;

  logic clk = 1'b0;
  logic rst;
  logic cyc;
  logic stb;
  logic we;
  waddr_t adr;
  word_t dat_w;
  word_t dat_r;
  logic ack;

  // one entry per trace line.
  byte ops[$];
  waddr_t addrs[$];
  word_t wr_data[$];
  word_t exp_data[$];
  byte kinds[$];

  bit trace_ready;
  int data_errors;
  int timing_errors;
  int trace_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  cached_mem cached_mem_i (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  task automatic load_trace();
    int fd;
    int n;
    byte op;
    byte kind;
    waddr_t a;
    word_t d;
    word_t e;
    logic [8*128-1:0] rest;
    fd = $fopen("bench/cached_mem_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file bench/cached_mem_trace.txt.");
      trace_errors++;
    end else begin
      while ($fscanf(fd, " %c", op) == 1) begin
        if (op == "#") begin
          n = $fgets(rest, fd);   // comment line.
        end else begin
          n = $fscanf(fd, " %h %h %h %c", a, d, e, kind);
          if (n != 4 || !(op == "R" || op == "W") || !(kind == "H" || kind == "M")) begin
            $display("trace entry %0d is malformed.", ops.size() + 1);
            trace_errors++;
          end else begin
            ops.push_back(op);
            addrs.push_back(a);
            wr_data.push_back(d);
            exp_data.push_back(e);
            kinds.push_back(kind);
          end
        end
      end
      $fclose(fd);
      if (ops.size() == 0) begin
        $display("the trace file holds no operations.");
        trace_errors++;
      end
    end
  endtask

  // one Wishbone cycle, counts the edges between stb sampling and ack.
  task automatic run_access(input byte op, input waddr_t a, input word_t d, output int edges);
    cyc = 1'b1;
    stb = 1'b1;
    we = (op == "W");
    adr = a;
    dat_w = d;
    edges = 0;
    @(posedge clk);   // this edge samples stb.
    @(negedge clk);
    while (!ack) begin
      edges++;
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  task automatic check_word(input waddr_t a, input word_t exp, input word_t got);
    if (got !== exp) begin
      data_errors++;
      $display("FAILED at %0t ns: read of %h returned %h, expected %h", $time, a, got, exp);
    end
  endtask

  task automatic check_latency(input waddr_t a, input int exp, input int got);
    if (got != exp) begin
      timing_errors++;
      $display("FAILED at %0t ns: hit on %h acked after %0d cycles, expected %0d",
               $time, a, got, exp);
    end
  endtask

  initial begin
    int edges;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    load_trace();
    trace_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst = 1'b0;
    // the tag sweep runs now, the first request just waits for it.
    foreach (ops[i]) begin
      @(posedge clk);
      #10;
      run_access(ops[i], addrs[i], wr_data[i], edges);
      if (ops[i] == "R") begin
        check_word(addrs[i], exp_data[i], dat_r);
      end
      if (kinds[i] == "H") begin
        check_latency(addrs[i], HIT_CYCLES, edges);
      end
    end
    @(posedge clk);
    #10;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    $display("errors: %0d data, %0d timing, %0d trace", data_errors, timing_errors,
             trace_errors);
    if (data_errors + timing_errors + trace_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // budget covers reset, the tag sweep and a worst-case miss per line.
  initial begin
    time limit;
    wait (trace_ready);
    limit = (ops.size() * CYCLES_PER_OP + RESET_CYCLES + `CACHE_LINES) * CLK_PERIOD;
    #(limit);
    $display("the run timed out at %0t ns while waiting for ack.", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- bench/cached_mem_trace.txt
# op addr wdata expected kind, all values hex, kind H is a hit and M a miss
# write lines ignore the expected column
# power-up contents through a fill
R 000140 00000000 5A5A0E4F M
R 000145 00000000 5A5A0E4A H
# miss on a middle offset, then every word of the line
R 000284 00000000 5A5A0D8B M
R 000285 00000000 5A5A0D8A H
R 000286 00000000 5A5A0D89 H
R 000287 00000000 5A5A0D88 H
R 000280 00000000 5A5A0D8F H
R 000281 00000000 5A5A0D8E H
R 000282 00000000 5A5A0D8D H
R 000283 00000000 5A5A0D8C H
# write hit, then write miss with merge
W 000142 CAFE0142 00000000 H
R 000142 00000000 CAFE0142 H
W 00100B 1234ABCD 00000000 M
R 00100B 00000000 1234ABCD H
R 00100C 00000000 5A5A1F03 H
# dirty eviction by a conflicting line, then refill
W 000147 0BADF00D 00000000 H
R 000344 00000000 5A5A0C4B M
R 000342 00000000 5A5A0C4D H
R 000142 00000000 CAFE0142 M
R 000147 00000000 0BADF00D H
R 000140 00000000 5A5A0E4F H
# conflicting line keeps its own contents
R 000347 00000000 5A5A0C48 M
R 000340 00000000 5A5A0C4F H
# write miss on a dirty line, then back and forth
W 00120E 7E57DA7A 00000000 M
R 00120E 00000000 7E57DA7A H
R 00100B 00000000 1234ABCD M
R 00120E 00000000 7E57DA7A M
R 00100C 00000000 5A5A1F03 M

//--- list.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/burst_ram.sv
hdl/line_cache.sv
hdl/cached_mem.sv
bench/cached_mem_tb.sv

//--- Bender.yml
package:
  name: cached_mem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/cache_pkg.sv
      - hdl/cache_array.sv
      - hdl/burst_ram.sv
      - hdl/line_cache.sv
      - hdl/cached_mem.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/cached_mem_tb.sv
